//--- compile.f
src/evt_pkg.sv
src/evt_bit_encoder.sv
src/evt_pending_latch.sv
src/evt_credit_counter.sv
src/evt_dispatch_fsm.sv
src/evt_dispatch_top.sv
bench/evt_dispatch_tb.sv

//--- bench/evt_dispatch_tb.sv
// Event dispatcher testbench
// Drives the request lines and the consumer's credit returns from a
// table of rows. A reference model tracks pending events and credits
// on its own and predicts the index of every dispatch

`default_nettype none

module evt_dispatch_tb;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;        // Inputs move this long after a rising edge
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 20;
    localparam int ROW_TIMEOUT  = 400;      // Cycles a row may take before it is abandoned
    localparam int NUM_ROWS     = 6;

    // How the consumer hands credits back during a row
    typedef enum int {
        RET_NOW,                            // Return one credit per cycle as soon as possible
        RET_STARVE,                         // Hold credits back until the dispatcher stalls
        RET_RANDOM,                         // Return after random gaps
        RET_RACE                            // Like RET_NOW, plus a repeat pulse on the issued line
    } ret_mode_t;

    typedef struct {
        string             name;
        evt_pkg::evt_vec_t req;             // Request lines pulsed in the first cycle of the row
        int                returns;         // Credits returned during the row
        int                expected;        // Dispatches expected during the row
        int                first_cycle;     // Cycle of the first dispatch, or -1 if not checked
        ret_mode_t         mode;
    } row_t;

    logic              clk;
    logic              rst_n;
    evt_pkg::evt_vec_t req_lines;
    logic              credit_return;
    logic              out_valid;
    evt_pkg::evt_sel_t out_index;

    row_t rows [NUM_ROWS];

    // Reference model state
    evt_pkg::evt_vec_t model_pending;       // Pending bits during the current cycle
    evt_pkg::evt_vec_t seen_pending;        // Pending bits of the cycle before
    int                model_credit;

    // Progress of the running row
    string cur_name;
    int    cyc;
    int    n_disp;
    int    n_ret;
    int    first_disp;
    int    rand_gap;
    int    quiet_count;

    evt_dispatch_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_lines     (req_lines),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_index     (out_index)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERR %s expected %0d actual %0d", test, expected, actual));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    // Lowest set index wins and -1 means no event is pending
    function automatic int lowest_index(input evt_pkg::evt_vec_t v);
        int found;
        found = -1;
        for (int i = 0; i < evt_pkg::EVT_COUNT && found < 0; i++) begin
            if (v[i]) begin
                found = i;
            end
        end
        return found;
    endfunction

    // Called mid-cycle, when the registered DUT outputs are settled
    task automatic observe(input evt_pkg::evt_vec_t req, input logic ret);
        evt_pkg::evt_vec_t clr;
        int                expect_idx;
        clr = '0;
        if (out_valid !== 1'b0 && out_valid !== 1'b1) begin
            abort_run($sformatf("%s: out_valid is unknown in cycle %0d", cur_name, cyc));
        end
        if (out_valid) begin
            // The choice was made from what was pending one cycle earlier
            expect_idx = lowest_index(seen_pending);
            if (expect_idx < 0) begin
                abort_run($sformatf("%s: out_valid rose with no event pending", cur_name));
            end
            if (model_credit == 0) begin
                abort_run($sformatf("%s: out_valid rose with no consumer credit left", cur_name));
            end
            check_value(cur_name, expect_idx, out_index);
            clr[expect_idx] = 1'b1;
            n_disp++;
            if (first_disp < 0) begin
                first_disp = cyc;
            end
        end
        seen_pending  = model_pending;
        model_pending = (model_pending & ~clr) | req;   // A new request beats the clear
        if (out_valid && !ret) begin
            model_credit--;
        end else if (!out_valid && ret && model_credit < evt_pkg::CREDIT_MAX) begin
            model_credit++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic tick(input evt_pkg::evt_vec_t req, input logic ret);
        req_lines     = req;
        credit_return = ret;
        @(negedge clk);
        observe(req, ret);
        @(posedge clk);
        #DRIVE_DELAY;
        cyc++;
    endtask

    task automatic choose_return(input row_t row, output logic ret);
        int   outstanding;
        logic can_ret;
        outstanding = n_disp - n_ret;
        can_ret     = (outstanding > 0) && (n_ret < row.returns);
        ret         = 1'b0;
        case (row.mode)
            RET_NOW, RET_RACE: begin
                ret = can_ret;
            end
            RET_RANDOM: begin
                if (can_ret) begin
                    if (rand_gap == 0) begin
                        ret      = 1'b1;
                        rand_gap = $urandom_range(6, 0);
                    end else begin
                        rand_gap--;
                    end
                end
            end
            RET_STARVE: begin
                if (n_disp == row.expected) begin
                    ret = can_ret;                      // All issued, give every credit back
                end else if (quiet_count < QUIET_CYCLES) begin
                    // Any dispatch in this window trips the model's credit check
                    if (n_disp == evt_pkg::CREDIT_MAX) begin
                        quiet_count++;
                    end
                end else begin
                    ret = can_ret && (outstanding == evt_pkg::CREDIT_MAX);
                end
            end
            default: begin
                ret = 1'b0;
            end
        endcase
        if (ret) begin
            n_ret++;
        end
    endtask

    task automatic run_row(input row_t row);
        evt_pkg::evt_vec_t req;
        logic              ret;
        cur_name    = row.name;
        cyc         = 0;
        n_disp      = 0;
        n_ret       = 0;
        first_disp  = -1;
        rand_gap    = 0;
        quiet_count = 0;
        while (cyc == 0 || n_disp < row.expected || n_ret < row.returns) begin
            if (cyc >= ROW_TIMEOUT) begin
                abort_run($sformatf("Timeout in %s: saw %0d of %0d dispatches, %0d of %0d returns",
                                    row.name, n_disp, row.expected, n_ret, row.returns));
            end
            req = '0;
            if (cyc == 0) begin
                req = row.req;
            end
            if (row.mode == RET_RACE && cyc == row.first_cycle) begin
                req = row.req;                          // Same line again while it is issued
            end
            choose_return(row, ret);
            tick(req, ret);
        end
        repeat (QUIET_CYCLES) tick('0, 1'b0);           // Nothing more may be dispatched
        check_value({row.name, "_count"}, row.expected, n_disp);
        if (row.first_cycle >= 0) begin
            check_value({row.name, "_latency"}, row.first_cycle, first_disp);
        end
        $display("%s: %0d dispatches", row.name, n_disp);
    endtask

    task automatic load_table();
        rows[0] = '{name: "idle_after_reset", req: 16'h0000, returns: 0, expected: 0,
                    first_cycle: -1, mode: RET_NOW};
        rows[1] = '{name: "single_line_9", req: 16'h0200, returns: 1, expected: 1,
                    first_cycle: 2, mode: RET_NOW};
        rows[2] = '{name: "order_0_3_7_12", req: 16'h1089, returns: 4, expected: 4,
                    first_cycle: 2, mode: RET_NOW};
        rows[3] = '{name: "credit_exhaust", req: 16'h0A5C, returns: 6, expected: 6,
                    first_cycle: 2, mode: RET_STARVE};
        rows[4] = '{name: "rerequest_race", req: 16'h0020, returns: 2, expected: 2,
                    first_cycle: 2, mode: RET_RACE};
        rows[5] = '{name: "random_gaps", req: 16'hB3D4, returns: 9, expected: 9,
                    first_cycle: 2, mode: RET_RANDOM};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(82));
        rst_n         = 1'b0;
        req_lines     = '0;
        credit_return = 1'b0;
        model_pending = '0;
        seen_pending  = '0;
        model_credit  = evt_pkg::CREDIT_MAX;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/evt_dispatch_top.sv
// Event dispatcher top level
// Sixteen request lines are held as pending bits and handed out one
// index at a time, lowest first, under credit flow control from the
// consumer. Up to CREDIT_MAX dispatches may be outstanding

`default_nettype none

module evt_dispatch_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire evt_pkg::evt_vec_t req_lines,
    input  wire                    credit_return,
    output logic                   out_valid,
    output evt_pkg::evt_sel_t      out_index
);

    evt_pkg::evt_vec_t pending;
    evt_pkg::evt_sel_t enc_sel;
    logic              enc_any;
    logic              credit_ok;
    logic              clr_valid;
    logic              take;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pending and select
    // ~~~~~~~~~~~~~~~~~~~~

    evt_pending_latch u_latch (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_lines (req_lines),
        .clr_valid (clr_valid),
        .clr_index (out_index),                         // The index being issued is the one cleared
        .pending   (pending)
    );

    evt_bit_encoder u_enc (
        .in_data (pending),
        .out_sel (enc_sel),
        .any     (enc_any)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Dispatch and credit
    // ~~~~~~~~~~~~~~~~~~~~

    evt_dispatch_fsm u_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .any       (enc_any),
        .sel       (enc_sel),
        .credit_ok (credit_ok),
        .out_valid (out_valid),
        .out_index (out_index),
        .clr_valid (clr_valid),
        .take      (take)
    );

    // Back-pressure comes only from here, there is no ready signal
    evt_credit_counter u_credit (
        .clk           (clk),
        .rst_n         (rst_n),
        .take          (take),
        .credit_return (credit_return),
        .credit_ok     (credit_ok)
    );

endmodule

`default_nettype wire

//--- src/evt_dispatch_fsm.sv
// Dispatch state machine
// Captures the encoder's choice while idle and presents it to the
// consumer for one cycle. The same cycle spends a credit and clears
// the pending bit, so one dispatch completes every two cycles at most

`default_nettype none

module evt_dispatch_fsm (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    any,
    input  wire evt_pkg::evt_sel_t sel,
    input  wire                    credit_ok,
    output logic                   out_valid,
    output evt_pkg::evt_sel_t      out_index,
    output logic                   clr_valid,
    output logic                   take
);

    evt_pkg::dispatch_state_t state_q;
    evt_pkg::dispatch_state_t state_next;
    evt_pkg::evt_sel_t        index_q;
    logic                     start;
    logic                     issue;

    // ~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~

    // A dispatch starts only when something is pending and the consumer
    // has a free slot
    assign start = any && credit_ok;

    always_comb begin
        state_next = state_q;
        case (state_q)
            evt_pkg::ST_IDLE: begin
                if (start) begin
                    state_next = evt_pkg::ST_ISSUE;
                end
            end
            evt_pkg::ST_ISSUE: begin
                state_next = evt_pkg::ST_IDLE;          // Always a single cycle
            end
            default: begin
                state_next = evt_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= evt_pkg::ST_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Index capture
    // ~~~~~~~~~~~~~~~~~~~~

    // The index is frozen on entry to ST_ISSUE. While issuing, the
    // encoder still sees the old bit, so it must not be sampled again
    always_ff @(posedge clk) begin
        if (state_q == evt_pkg::ST_IDLE && start) begin
            index_q <= sel;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~

    assign issue = (state_q == evt_pkg::ST_ISSUE);

    assign out_valid = issue;
    assign out_index = index_q;                         // Doubles as the clear index
    assign clr_valid = issue;                           // Bit drops at the end of this cycle
    assign take      = issue;

endmodule

`default_nettype wire

//--- src/evt_credit_counter.sv
// Consumer credit counter
// Tracks how many dispatches the consumer can still accept. A take
// spends one credit, a credit_return pulse gives one back. The count
// saturates at zero and at the full depth

`default_nettype none

module evt_credit_counter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  take,
    input  wire  credit_return,
    output logic credit_ok
);

    evt_pkg::credit_t count_q;
    logic             at_empty;
    logic             at_full;

    assign at_empty = (count_q == '0);
    assign at_full  = (count_q == evt_pkg::credit_t'(evt_pkg::CREDIT_MAX));

    // ~~~~~~~~~~~~~~~~~~~~
    // Count update
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= evt_pkg::credit_t'(evt_pkg::CREDIT_MAX);   // Every slot starts free
        end else begin
            case ({take, credit_return})
                2'b10: begin
                    if (!at_empty) begin
                        count_q <= count_q - 1'b1;
                    end
                end
                2'b01: begin
                    // A return beyond the full depth is dropped
                    if (!at_full) begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: begin
                    count_q <= count_q;                 // Idle, or take and return cancel
                end
            endcase
        end
    end

    assign credit_ok = !at_empty;

endmodule

`default_nettype wire

//--- src/evt_pending_latch.sv
// Pending event register
// Collects request pulses into one sticky bit per line and clears
// the single bit named by the dispatcher. A new request on the line
// being cleared keeps it pending

`default_nettype none

module evt_pending_latch (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire evt_pkg::evt_vec_t req_lines,
    input  wire                    clr_valid,
    input  wire evt_pkg::evt_sel_t clr_index,
    output evt_pkg::evt_vec_t      pending
);

    evt_pkg::evt_vec_t pending_q;
    evt_pkg::evt_vec_t clr_mask;

    // ~~~~~~~~~~~~~~~~~~~~
    // Clear decode
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        clr_mask = '0;
        if (clr_valid) begin
            clr_mask = evt_pkg::evt_vec_t'(1) << clr_index;     // One-hot of the index
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Pending bits
    // ~~~~~~~~~~~~~~~~~~~~

    // The clear is applied first and the requests are ORed in after it,
    // which gives the set priority when both hit the same bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_mask) | req_lines;
        end
    end

    assign pending = pending_q;

endmodule

`default_nettype wire

//--- src/evt_bit_encoder.sv
// Priority bit encoder
// Returns the index of the lowest set bit of the event vector and
// flags whether any bit is set at all. Purely combinational

`default_nettype none

module evt_bit_encoder (
    input  wire evt_pkg::evt_vec_t in_data,
    output evt_pkg::evt_sel_t      out_sel,
    output logic                   any
);

    evt_pkg::evt_sel_t sel_comb;

    // ~~~~~~~~~~~~~~~~~~~~
    // Lowest index first
    // ~~~~~~~~~~~~~~~~~~~~

    // Walks from the top bit down to bit 0. Each set bit overwrites the
    // result, so the lowest set bit is the one left standing when the
    // loop finishes
    always_comb begin
        sel_comb = '0;                                  // Zero when nothing is set
        for (int i = evt_pkg::EVT_COUNT - 1; i >= 0; i--) begin
            if (in_data[i]) begin
                sel_comb = evt_pkg::evt_sel_t'(i);
            end
        end
    end

    assign out_sel = sel_comb;
    assign any     = |in_data;                          // Reduction over all lines

endmodule

`default_nettype wire

//--- src/evt_pkg.sv
// Event dispatcher shared definitions
// Widths, the consumer credit depth, the vector typedefs and the
// dispatch state encoding used by every block of the dispatcher

`default_nettype none

package evt_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int EVT_COUNT    = 16;   // Number of request lines
    localparam int SEL_WIDTH    = 4;    // Enough to name any of the 16 lines
    localparam int CREDIT_MAX   = 4;    // Credit slots held by the consumer
    localparam int CREDIT_WIDTH = 3;    // Holds 0 through CREDIT_MAX

    // ~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~

    // Bit n belongs to request line n
    typedef logic [EVT_COUNT-1:0]    evt_vec_t;

    typedef logic [SEL_WIDTH-1:0]    evt_sel_t;     // Index of one event line
    typedef logic [CREDIT_WIDTH-1:0] credit_t;      // Count of free credits

    // ST_ISSUE of the dispatch FSM lasts exactly one cycle per dispatch
    typedef enum logic [0:0] {
        ST_IDLE  = 1'b0,
        ST_ISSUE = 1'b1
    } dispatch_state_t;

endpackage

`default_nettype wire
